/* cgra_dma_defines.svh */
// CGRA data mover, read path
// Sizing constants shared by the package and the RTL

`ifndef CGRA_DMA_DEFINES_SVH
`define CGRA_DMA_DEFINES_SVH

// Input nodes feeding the CGRA
`define CGRA_DMA_NODES 4

// Words buffered per node
`define CGRA_DMA_FIFO_DEPTH 10

// Reads in flight on the bus
`define CGRA_DMA_MAX_OUTST 4

// Data widths
`define CGRA_DMA_WORD_W 32
`define CGRA_DMA_BEAT_W 64

// Size and stride in bytes
`define CGRA_DMA_SIZE_W 16

`endif

/* cgra_dma_pkg.sv */
// CGRA data mover types
// Vector types, node configuration and the record kept per issued read

`include "cgra_dma_defines.svh"

package cgra_dma_pkg;

    // Byte address on the bus
    typedef logic [31:0] addr_t;

    typedef logic [`CGRA_DMA_WORD_W-1:0] word_t;
    typedef logic [`CGRA_DMA_BEAT_W-1:0] beat_t;

    // Byte count, for size and stride alike
    typedef logic [`CGRA_DMA_SIZE_W-1:0] size_t;

    // One bit per node, one-hot for grants
    typedef logic [`CGRA_DMA_NODES-1:0] node_mask_t;

    // Node FIFO fill level, 0 up to full depth
    typedef logic [$clog2(`CGRA_DMA_FIFO_DEPTH):0] fifo_cnt_t;

    // Read stream of one node
    typedef struct packed {
        addr_t base;
        size_t size;
        size_t stride;
    } node_cfg_t;

    // Destination of a read that is still in flight
    typedef struct packed {
        node_mask_t node;
        logic       upper_word;
    } outst_info_t;

endpackage

/* rr_arbiter.sv */
// Round-robin arbiter with one-hot grant
// Search starts one past the last granted request and wraps around

`timescale 1ns/10ps

module rr_arbiter #(
    parameter int unsigned WIDTH = 4
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic [WIDTH-1:0] req_i,
    input  logic             enable_i,
    output logic [WIDTH-1:0] gnt_o
);

    logic [WIDTH-1:0]   ptr_q, ptr_d;
    logic [2*WIDTH-1:0] double_req;
    logic [2*WIDTH-1:0] double_gnt;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ptr_q <= WIDTH'(1);
        end else begin
            ptr_q <= ptr_d;
        end
    end

    always_comb begin
        // Subtracting the pointer clears the first request at or above it,
        // masking with the request then leaves only that bit.
        // The doubled vector covers the wrap past the top bit
        double_req = {req_i, req_i};
        double_gnt = double_req & ~(double_req - {{WIDTH{1'b0}}, ptr_q});

        if (enable_i) begin
            gnt_o = double_gnt[WIDTH-1:0] | double_gnt[2*WIDTH-1:WIDTH];
        end else begin
            gnt_o = '0;
        end

        // Next search starts just above the winner
        if (gnt_o != '0) begin
            ptr_d = {gnt_o[WIDTH-2:0], gnt_o[WIDTH-1]};
        end else begin
            ptr_d = ptr_q;
        end
    end

endmodule

/* sync_fifo.sv */
// Synchronous FIFO with fill level
// Circular buffer, head word read straight from storage

`timescale 1ns/10ps

module sync_fifo #(
    parameter int unsigned DEPTH = 4,
    parameter type         T     = logic [7:0]
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   push_i,
    input  T                       data_i,
    input  logic                   pop_i,
    output T                       data_o,
    output logic                   full_o,
    output logic                   empty_o,
    output logic [$clog2(DEPTH):0] usage_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH) + 1;

    T                   mem_q [DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   usage_q;
    logic               do_push;
    logic               do_pop;

    assign full_o  = (usage_q == CNT_W'(DEPTH));
    assign empty_o = (usage_q == '0);
    assign usage_o = usage_q;

    // Requests beyond the limits are dropped
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign data_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            usage_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end

            // Level only moves when exactly one side acts
            case ({do_push, do_pop})
                2'b10:   usage_q <= usage_q + 1'b1;
                2'b01:   usage_q <= usage_q - 1'b1;
                default: usage_q <= usage_q;
            endcase
        end
    end

endmodule

/* read_addr_gen.sv */
// Read address generation for the CGRA input nodes
// Tracks the run and each node's offset, arbitrates between nodes
// and drives the AR channel one read at a time

`timescale 1ns/10ps
`include "cgra_dma_defines.svh"

module read_addr_gen (
    input  logic                                          clk_i,
    input  logic                                          rst_ni,
    input  logic                                          start_i,
    input  cgra_dma_pkg::node_cfg_t [`CGRA_DMA_NODES-1:0] node_cfg_i,
    input  cgra_dma_pkg::fifo_cnt_t [`CGRA_DMA_NODES-1:0] node_usage_i,
    input  logic                                          outst_full_i,
    input  logic                                          outst_empty_i,
    input  logic                                          ar_ready_i,
    output cgra_dma_pkg::addr_t                           ar_addr_o,
    output logic                                          ar_valid_o,
    output logic                                          outst_push_o,
    output cgra_dma_pkg::outst_info_t                     outst_info_o,
    output logic                                          busy_o
);

    import cgra_dma_pkg::*;

    // Room left for every read that may still be in flight
    localparam fifo_cnt_t REQ_LIMIT =
        fifo_cnt_t'(`CGRA_DMA_FIFO_DEPTH - `CGRA_DMA_MAX_OUTST);

    logic                        busy_q, busy_d;
    logic                        run_end;
    logic                        wait_q, wait_d;
    logic                        ar_free;
    size_t [`CGRA_DMA_NODES-1:0] offs_q, offs_d;
    node_mask_t                  node_done;
    node_mask_t                  arb_req;
    node_mask_t                  arb_gnt;
    logic                        arb_en;
    logic                        new_ar;
    addr_t                       gnt_addr;
    addr_t                       addr_q;

    // Run control and requests
    always_comb begin
        for (int i = 0; i < `CGRA_DMA_NODES; i++) begin
            node_done[i] = (offs_q[i] >= node_cfg_i[i].size);
            arb_req[i]   = !node_done[i] && (node_usage_i[i] < REQ_LIMIT);
        end

        // Finished only once all streams are issued and all data is back
        run_end = busy_q && (&node_done) && outst_empty_i;
        busy_d  = start_i || (busy_q && !run_end);
    end

    // AR slot is free when idle or when the pending request is taken
    assign ar_free = !wait_q || ar_ready_i;
    assign arb_en  = busy_q && ar_free && !outst_full_i;
    assign new_ar  = |arb_gnt;
    assign wait_d  = new_ar || (wait_q && !ar_ready_i);

    rr_arbiter #(
        .WIDTH ( `CGRA_DMA_NODES )
    ) i_rr_arbiter (
        .clk_i    ( clk_i   ),
        .rst_ni   ( rst_ni  ),
        .req_i    ( arb_req ),
        .enable_i ( arb_en  ),
        .gnt_o    ( arb_gnt )
    );

    // Address of the granted node and offset update
    always_comb begin
        gnt_addr = '0;
        offs_d   = offs_q;
        for (int i = 0; i < `CGRA_DMA_NODES; i++) begin
            if (arb_gnt[i]) begin
                gnt_addr  = node_cfg_i[i].base + addr_t'(offs_q[i]);
                offs_d[i] = offs_q[i] + node_cfg_i[i].stride;
            end
        end

        // Next run restarts every stream at its base
        if (run_end) begin
            offs_d = '0;
        end
    end

    // Bit 2 picks the 32-bit half of the 64-bit beat
    assign outst_push_o            = new_ar;
    assign outst_info_o.node       = arb_gnt;
    assign outst_info_o.upper_word = gnt_addr[2];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            wait_q <= 1'b0;
            offs_q <= '0;
        end else begin
            busy_q <= busy_d;
            wait_q <= wait_d;
            offs_q <= offs_d;
        end
    end

    // Held while the AR request waits for ready
    always_ff @(posedge clk_i) begin
        if (new_ar) begin
            addr_q <= gnt_addr;
        end
    end

    assign ar_addr_o  = {addr_q[31:3], 3'b000};
    assign ar_valid_o = wait_q;
    assign busy_o     = busy_q;

endmodule

/* read_data_steer.sv */
// Read data steering toward the CGRA input nodes
// Matches each returned beat with its queued request, picks the word
// and buffers it in that node's FIFO

`timescale 1ns/10ps
`include "cgra_dma_defines.svh"

module read_data_steer (
    input  logic                                          clk_i,
    input  logic                                          rst_ni,
    input  logic                                          outst_push_i,
    input  cgra_dma_pkg::outst_info_t                     outst_info_i,
    input  cgra_dma_pkg::beat_t                           r_data_i,
    input  logic                                          r_valid_i,
    input  cgra_dma_pkg::node_mask_t                      ready_i,
    output logic                                          outst_full_o,
    output logic                                          outst_empty_o,
    output cgra_dma_pkg::fifo_cnt_t [`CGRA_DMA_NODES-1:0] node_usage_o,
    output cgra_dma_pkg::word_t [`CGRA_DMA_NODES-1:0]     data_o,
    output cgra_dma_pkg::node_mask_t                      valid_o
);

    import cgra_dma_pkg::*;

    outst_info_t head_info;
    word_t       beat_word;
    node_mask_t  node_push;
    node_mask_t  node_pop;
    node_mask_t  node_empty;

    // Beats come back in request order
    sync_fifo #(
        .DEPTH ( `CGRA_DMA_MAX_OUTST ),
        .T     ( outst_info_t        )
    ) i_outst_fifo (
        .clk_i   ( clk_i         ),
        .rst_ni  ( rst_ni        ),
        .push_i  ( outst_push_i  ),
        .data_i  ( outst_info_i  ),
        .pop_i   ( r_valid_i     ),
        .data_o  ( head_info     ),
        .full_o  ( outst_full_o  ),
        .empty_o ( outst_empty_o ),
        .usage_o (               )
    );

    assign beat_word = head_info.upper_word ?
                       r_data_i[2*`CGRA_DMA_WORD_W-1:`CGRA_DMA_WORD_W] :
                       r_data_i[`CGRA_DMA_WORD_W-1:0];

    assign node_push = r_valid_i ? head_info.node : '0;

    assign valid_o  = ~node_empty;
    assign node_pop = valid_o & ready_i;

    for (genvar i = 0; i < `CGRA_DMA_NODES; i++) begin : gen_node_fifo
        sync_fifo #(
            .DEPTH ( `CGRA_DMA_FIFO_DEPTH ),
            .T     ( word_t               )
        ) i_node_fifo (
            .clk_i   ( clk_i           ),
            .rst_ni  ( rst_ni          ),
            .push_i  ( node_push[i]    ),
            .data_i  ( beat_word       ),
            .pop_i   ( node_pop[i]     ),
            .data_o  ( data_o[i]       ),
            .full_o  (                 ),
            .empty_o ( node_empty[i]   ),
            .usage_o ( node_usage_o[i] )
        );
    end

endmodule

/* cgra_dma_read.sv */
// CGRA data mover, read path top level
// Streams each node's words from memory over the AR and R channels
// into per-node FIFOs read by the CGRA

`timescale 1ns/10ps
`include "cgra_dma_defines.svh"

module cgra_dma_read (
    input  logic                                          clk_i,
    input  logic                                          rst_ni,
    input  logic                                          start_i,
    input  cgra_dma_pkg::node_cfg_t [`CGRA_DMA_NODES-1:0] node_cfg_i,
    // AR channel
    output cgra_dma_pkg::addr_t                           ar_addr_o,
    output logic                                          ar_valid_o,
    input  logic                                          ar_ready_i,
    // R channel, always accepted
    input  cgra_dma_pkg::beat_t                           r_data_i,
    input  logic                                          r_valid_i,
    // CGRA input nodes
    output cgra_dma_pkg::word_t [`CGRA_DMA_NODES-1:0]     data_o,
    output cgra_dma_pkg::node_mask_t                      valid_o,
    input  cgra_dma_pkg::node_mask_t                      ready_i,
    output logic                                          read_busy_o
);

    import cgra_dma_pkg::*;

    logic                            outst_push;
    outst_info_t                     outst_info;
    logic                            outst_full;
    logic                            outst_empty;
    fifo_cnt_t [`CGRA_DMA_NODES-1:0] node_usage;

    read_addr_gen i_read_addr_gen (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .start_i       ( start_i     ),
        .node_cfg_i    ( node_cfg_i  ),
        .node_usage_i  ( node_usage  ),
        .outst_full_i  ( outst_full  ),
        .outst_empty_i ( outst_empty ),
        .ar_ready_i    ( ar_ready_i  ),
        .ar_addr_o     ( ar_addr_o   ),
        .ar_valid_o    ( ar_valid_o  ),
        .outst_push_o  ( outst_push  ),
        .outst_info_o  ( outst_info  ),
        .busy_o        ( read_busy_o )
    );

    read_data_steer i_read_data_steer (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .outst_push_i  ( outst_push  ),
        .outst_info_i  ( outst_info  ),
        .r_data_i      ( r_data_i    ),
        .r_valid_i     ( r_valid_i   ),
        .ready_i       ( ready_i     ),
        .outst_full_o  ( outst_full  ),
        .outst_empty_o ( outst_empty ),
        .node_usage_o  ( node_usage  ),
        .data_o        ( data_o      ),
        .valid_o       ( valid_o     )
    );

endmodule

/* tb_cgra_dma_read.sv */
// Testbench for the CGRA data mover read path
// Random bus timing, in-order memory model and a scoreboard per node

`timescale 1ns/10ps
`include "cgra_dma_defines.svh"

module tb_cgra_dma_read;

    import cgra_dma_pkg::*;

    localparam int unsigned NODES       = `CGRA_DMA_NODES;
    localparam logic [31:0] MEM_KEY     = 32'hc3a50000;
    localparam int unsigned HOLD_CYCLES = 80;

    logic                  clk_i = 1'b0;
    logic                  rst_ni;
    logic                  start_i;
    node_cfg_t [NODES-1:0] node_cfg_i;
    addr_t                 ar_addr_o;
    logic                  ar_valid_o;
    logic                  ar_ready_i;
    beat_t                 r_data_i;
    logic                  r_valid_i;
    word_t [NODES-1:0]     data_o;
    node_mask_t            valid_o;
    node_mask_t            ready_i;
    logic                  read_busy_o;

    node_cfg_t [NODES-1:0] cfg_a;
    node_cfg_t [NODES-1:0] cfg_b;
    int unsigned           errors;
    int unsigned           checks;
    int unsigned           cycle;
    int unsigned           timeout_limit;
    logic [31:0]           rng;

    // Memory model state, filled in request order
    addr_t                 ar_q [$];
    int unsigned           due_q [$];
    addr_t                 r_addr;
    int unsigned           bus_cycle;
    int                    accepted;
    int                    returned;

    // Scoreboard state of the current run
    int unsigned           run_no;
    int unsigned           run_cycle;
    int unsigned           beats_run;
    int unsigned           exp_total;
    int unsigned           exp_idx [NODES];
    int                    pushed [NODES];
    int                    popped [NODES];
    logic                  busy_prev;
    logic                  busy_fell;
    logic                  run_done;
    logic                  ar_stall;
    addr_t                 ar_addr_prev;

    cgra_dma_read i_cgra_dma_read (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .start_i     ( start_i     ),
        .node_cfg_i  ( node_cfg_i  ),
        .ar_addr_o   ( ar_addr_o   ),
        .ar_valid_o  ( ar_valid_o  ),
        .ar_ready_i  ( ar_ready_i  ),
        .r_data_i    ( r_data_i    ),
        .r_valid_i   ( r_valid_i   ),
        .data_o      ( data_o      ),
        .valid_o     ( valid_o     ),
        .ready_i     ( ready_i     ),
        .read_busy_o ( read_busy_o )
    );

    always #5 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic node_cfg_t make_cfg(input addr_t base, input int unsigned size,
                                           input int unsigned stride);
        node_cfg_t cfg;
        cfg.base   = base;
        cfg.size   = size_t'(size);
        cfg.stride = size_t'(stride);
        return cfg;
    endfunction

    // Offsets base, base+stride, ... while still below the size
    function automatic int unsigned count_words(input node_cfg_t cfg);
        int unsigned cnt;
        int unsigned off;
        cnt = 0;
        off = 0;
        while (off < cfg.size) begin
            cnt++;
            off += cfg.stride;
        end
        return cnt;
    endfunction

    function automatic int unsigned total_words(input node_cfg_t [NODES-1:0] cfg);
        int unsigned sum;
        sum = 0;
        for (int n = 0; n < NODES; n++) begin
            sum += count_words(cfg[n]);
        end
        return sum;
    endfunction

    function automatic word_t mem_word(input addr_t addr);
        return addr ^ MEM_KEY;
    endfunction

    // Node regions are disjoint, so a beat address names its node
    function automatic int node_of(input addr_t addr);
        int idx;
        idx = -1;
        for (int n = 0; n < NODES; n++) begin
            if (addr >= {node_cfg_i[n].base[31:3], 3'b000} &&
                addr < node_cfg_i[n].base + addr_t'(node_cfg_i[n].size)) begin
                idx = n;
            end
        end
        return idx;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            $display("ERROR: %s", msg);
            errors++;
        end
    endtask

    // Load the nodes, pulse start and wait until all words are taken
    task automatic run_stream(input node_cfg_t [NODES-1:0] cfg);
        @(posedge clk_i);
        node_cfg_i <= cfg;
        start_i    <= 1'b1;
        @(posedge clk_i);
        start_i <= 1'b0;
        @(posedge clk_i);
        check_true(read_busy_o, "read_busy_o not high the cycle after start");
        do begin
            @(posedge clk_i);
        end while (!run_done);
    endtask

    // Memory model, CGRA side and checks
    always @(posedge clk_i) begin : bus_model
        int         dst;
        addr_t      exp_addr;
        node_mask_t rdy;
        logic       drained;
        if (rst_ni) begin
            rng = xorshift(rng);
            bus_cycle++;

            if (start_i) begin
                run_no++;
                run_cycle = 0;
                beats_run = 0;
                busy_fell = 1'b0;
                exp_total = total_words(node_cfg_i);
                for (int n = 0; n < NODES; n++) begin
                    exp_idx[n] = 0;
                    pushed[n]  = 0;
                    popped[n]  = 0;
                end
            end else begin
                run_cycle++;
            end

            // AR request must hold until taken
            if (ar_stall) begin
                check_true(ar_valid_o, "ar_valid_o dropped before ar_ready_i");
                check_value("ar_addr_hold", ar_addr_prev, ar_addr_o);
            end
            if (ar_valid_o) begin
                check_value("ar_addr_align", 32'h0, {29'h0, ar_addr_o[2:0]});
            end
            ar_stall     = ar_valid_o && !ar_ready_i;
            ar_addr_prev = ar_addr_o;

            // Beat taken by the DUT in this cycle
            if (r_valid_i) begin
                dst = node_of(r_addr);
                check_true(dst >= 0, "returned beat belongs to no node");
                if (dst >= 0) begin
                    pushed[dst]++;
                end
                beats_run++;
                returned++;
            end

            for (int n = 0; n < NODES; n++) begin
                if (node_cfg_i[n].size == '0) begin
                    check_true(!valid_o[n], $sformatf("node %0d with size zero is valid", n));
                end
                if (valid_o[n] && ready_i[n]) begin
                    popped[n]++;
                    if (exp_idx[n] < count_words(node_cfg_i[n])) begin
                        exp_addr = node_cfg_i[n].base + exp_idx[n] * node_cfg_i[n].stride;
                        check_value("node_data", mem_word(exp_addr), data_o[n]);
                        exp_idx[n]++;
                    end else begin
                        check_true(1'b0, $sformatf("node %0d delivered an extra word", n));
                    end
                end
                check_true(pushed[n] - popped[n] <= `CGRA_DMA_FIFO_DEPTH,
                           $sformatf("node %0d holds more words than its FIFO depth", n));
            end

            if (ar_valid_o && ar_ready_i) begin
                ar_q.push_back(ar_addr_o);
                due_q.push_back(bus_cycle + 1 + 32'(rng[14:12]) % 6);
                accepted++;
            end
            check_true(accepted - returned <= `CGRA_DMA_MAX_OUTST,
                       "more reads in flight than the outstanding limit");

            // End of run only once every read is back
            if (busy_prev && !read_busy_o) begin
                busy_fell = 1'b1;
                check_value("read_beats", exp_total, beats_run);
                check_true(ar_q.size() == 0 && !r_valid_i,
                           "read_busy_o fell with reads still in flight");
            end
            busy_prev = read_busy_o;

            drained = 1'b1;
            for (int n = 0; n < NODES; n++) begin
                if (exp_idx[n] != count_words(node_cfg_i[n])) begin
                    drained = 1'b0;
                end
            end
            run_done <= busy_fell && drained && !start_i;

            if (ar_q.size() > 0 && due_q[0] <= bus_cycle) begin
                r_valid_i <= 1'b1;
                r_data_i  <= {mem_word(ar_q[0] + 32'd4), mem_word(ar_q[0])};
                r_addr     = ar_q[0];
                void'(ar_q.pop_front());
                void'(due_q.pop_front());
            end else begin
                r_valid_i <= 1'b0;
            end

            // Random handshakes with node 0 stalled early in the first run
            for (int n = 0; n < NODES; n++) begin
                rdy[n] = (rng[4+2*n +: 2] != 2'b00);
            end
            if (run_no == 1 && run_cycle < HOLD_CYCLES) begin
                rdy[0] = 1'b0;
            end
            ready_i    <= rdy;
            ar_ready_i <= (rng[1:0] != 2'b00);
        end
    end

    always @(posedge clk_i) begin : watchdog
        cycle++;
        if (cycle > timeout_limit) begin
            $display("ERROR: run did not finish within %0d cycles", timeout_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        rst_ni     = 1'b0;
        start_i    = 1'b0;
        node_cfg_i = '0;
        ar_ready_i = 1'b0;
        r_data_i   = '0;
        r_valid_i  = 1'b0;
        ready_i    = '0;
        rng        = 32'h4af4df5a;
        errors     = 0;
        checks     = 0;
        cycle      = 0;
        bus_cycle  = 0;
        accepted   = 0;
        returned   = 0;
        run_no     = 0;
        run_cycle  = 0;
        beats_run  = 0;
        exp_total  = 0;
        busy_prev  = 1'b0;
        busy_fell  = 1'b0;
        run_done   = 1'b0;
        ar_stall   = 1'b0;
        for (int n = 0; n < NODES; n++) begin
            exp_idx[n] = 0;
            pushed[n]  = 0;
            popped[n]  = 0;
        end

        // Upper halves, a size zero node and a size not a multiple of stride
        cfg_a[0] = make_cfg(32'h1000_0000, 40, 4);
        cfg_a[1] = make_cfg(32'h1000_0104, 36, 8);
        cfg_a[2] = make_cfg(32'h1000_0200, 0, 4);
        cfg_a[3] = make_cfg(32'h1000_0308, 22, 4);
        cfg_b[0] = make_cfg(32'h2000_0004, 32, 8);
        cfg_b[1] = make_cfg(32'h2000_0100, 12, 4);
        cfg_b[2] = make_cfg(32'h2000_0200, 20, 4);
        cfg_b[3] = make_cfg(32'h2000_0300, 16, 8);
        timeout_limit = 40 * (2 * total_words(cfg_a) + total_words(cfg_b)) + 200;

        repeat (16) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);
        check_true(!ar_valid_o && valid_o == '0 && !read_busy_o,
                   "outputs not idle after reset");

        run_stream(cfg_a);
        run_stream(cfg_b);
        run_stream(cfg_a);
        repeat (4) @(posedge clk_i);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* cgra_dma_read.f */
+incdir+.
cgra_dma_pkg.sv
rr_arbiter.sv
sync_fifo.sv
read_addr_gen.sv
read_data_steer.sv
cgra_dma_read.sv
tb_cgra_dma_read.sv

/* Bender.yml */
package:
  name: cgra_dma_read

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cgra_dma_pkg.sv
      - rr_arbiter.sv
      - sync_fifo.sv
      - read_addr_gen.sv
      - read_data_steer.sv
      - cgra_dma_read.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cgra_dma_read.sv
